// File: files.f
+incdir+include
verilog/lane_pkg.sv
verilog/burst_pkg.sv
verilog/byte_lane_fifo.sv
verilog/stream_read_port.sv
verilog/stream_write_port.sv
verilog/transport_layer.sv
testbench/tb_transport_layer.sv

// File: Makefile
TOP := tb_transport_layer

.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module $(TOP) -Mdir obj_dir -f files.f
	./obj_dir/V$(TOP) | awk '{ print } /^TEST RESULT: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// File: testbench/tb_transport_layer.sv
`timescale 1ns/1ps
`include "tl_defines.svh"

module tb_transport_layer
    import lane_pkg::*;
    import burst_pkg::*;
();

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 10;
    localparam int NUM_ALIGNED    = 4;
    localparam int NUM_MISALIGNED = 20;
    localparam int NUM_STALLED    = 20;
    localparam int NUM_RESPONSE   = 8;
    localparam int NUM_TRANSFERS  = NUM_ALIGNED + NUM_MISALIGNED + NUM_STALLED + NUM_RESPONSE;
    localparam int LANES          = `TL_STRB_WIDTH;
    localparam int MAX_LENGTH     = 40;
    // Worst case is an offset of 3 plus the longest transfer
    localparam int MAX_BEATS      = (LANES - 1 + MAX_LENGTH + LANES - 1) / LANES;
    localparam int WATCHDOG_CYCLES = NUM_TRANSFERS * MAX_BEATS * 20;

    logic      clk_i = 1'b0;
    logic      rst_n_i;
    logic      r_req_valid_i;
    logic      r_req_ready_o;
    lane_idx_t r_req_offset_i;
    lane_idx_t r_req_tailer_i;
    lane_idx_t r_req_shift_i;
    beat_cnt_t r_req_num_beats_i;
    logic      r_rsp_valid_o;
    logic      r_rsp_ready_i;
    logic      w_req_valid_i;
    logic      w_req_ready_o;
    lane_idx_t w_req_offset_i;
    lane_idx_t w_req_tailer_i;
    lane_idx_t w_req_shift_i;
    beat_cnt_t w_req_num_beats_i;
    logic      w_rsp_valid_o;
    logic      w_rsp_ready_i;
    logic      in_valid_i;
    logic      in_ready_o;
    data_t     in_data_i;
    logic      out_valid_o;
    logic      out_ready_i;
    data_t     out_data_o;
    strb_t     out_strb_o;
    logic      out_last_o;
    logic      r_busy_o;
    logic      w_busy_o;
    logic      buffer_busy_o;

    logic [31:0] rand_state;
    int          error_count;
    int          check_count;
    // Source bytes in stream order, waiting to come out
    byte_t       model_q[$];

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    transport_layer u_dut (
        .clk_i             ( clk_i             ),
        .rst_n_i           ( rst_n_i           ),
        .r_req_valid_i     ( r_req_valid_i     ),
        .r_req_ready_o     ( r_req_ready_o     ),
        .r_req_offset_i    ( r_req_offset_i    ),
        .r_req_tailer_i    ( r_req_tailer_i    ),
        .r_req_shift_i     ( r_req_shift_i     ),
        .r_req_num_beats_i ( r_req_num_beats_i ),
        .r_rsp_valid_o     ( r_rsp_valid_o     ),
        .r_rsp_ready_i     ( r_rsp_ready_i     ),
        .w_req_valid_i     ( w_req_valid_i     ),
        .w_req_ready_o     ( w_req_ready_o     ),
        .w_req_offset_i    ( w_req_offset_i    ),
        .w_req_tailer_i    ( w_req_tailer_i    ),
        .w_req_shift_i     ( w_req_shift_i     ),
        .w_req_num_beats_i ( w_req_num_beats_i ),
        .w_rsp_valid_o     ( w_rsp_valid_o     ),
        .w_rsp_ready_i     ( w_rsp_ready_i     ),
        .in_valid_i        ( in_valid_i        ),
        .in_ready_o        ( in_ready_o        ),
        .in_data_i         ( in_data_i         ),
        .out_valid_o       ( out_valid_o       ),
        .out_ready_i       ( out_ready_i       ),
        .out_data_o        ( out_data_o        ),
        .out_strb_o        ( out_strb_o        ),
        .out_last_o        ( out_last_o        ),
        .r_busy_o          ( r_busy_o          ),
        .w_busy_o          ( w_busy_o          ),
        .buffer_busy_o     ( buffer_busy_o     )
    );

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rand_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rand_state = x;
        return x;
    endfunction

    function automatic int random_below(input int n);
        return int'(next_random() % n);
    endfunction

    // Lanes of one beat: first beat from offset up, last beat below a nonzero tailer
    function automatic strb_t lane_mask(input int beat, input int num_beats,
                                        input int offset, input int tailer);
        strb_t mask;
        for (int lane = 0; lane < LANES; lane++) begin
            mask[lane] = 1'b1;
            if (beat == 0 && lane < offset) begin
                mask[lane] = 1'b0;
            end
            if (beat == num_beats - 1 && tailer != 0 && lane >= tailer) begin
                mask[lane] = 1'b0;
            end
        end
        return mask;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("ERROR at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
        end
    endtask

    task automatic report_test(input int number, input string name, input int errors_before);
        $display("Test %0d %s: %0d errors, %s", number, name, error_count - errors_before,
                 (error_count == errors_before) ? "passed" : "failed");
    endtask

    // ----------------------------------------------------------------------
    // One transfer, all handshakes decided on the falling edge
    // ----------------------------------------------------------------------

    task automatic run_transfer(input int length, input int src_off, input int dst_off,
                                input int gap_pct, input int stall_pct, input int rsp_pct);
        int    src_beats;
        int    dst_beats;
        int    src_tailer;
        int    dst_tailer;
        int    src_sent;
        int    dst_recv;
        int    r_rsp_seen;
        int    w_rsp_seen;
        logic  r_req_fire;
        logic  w_req_fire;
        logic  in_fire;
        logic  stalled;
        strb_t src_mask;
        strb_t exp_strb;
        data_t beat;
        data_t held_data;
        strb_t held_strb;
        logic  held_last;
        src_beats  = (src_off + length + LANES - 1) / LANES;
        dst_beats  = (dst_off + length + LANES - 1) / LANES;
        src_tailer = (src_off + length) % LANES;
        dst_tailer = (dst_off + length) % LANES;
        src_sent   = 0;
        dst_recv   = 0;
        r_rsp_seen = 0;
        w_rsp_seen = 0;
        stalled    = 1'b0;
        src_mask   = '0;
        held_data  = '0;
        held_strb  = '0;
        held_last  = 1'b0;

        @(negedge clk_i);
        r_req_valid_i     = 1'b1;
        r_req_offset_i    = lane_idx_t'(src_off);
        r_req_tailer_i    = lane_idx_t'(src_tailer);
        r_req_shift_i     = lane_idx_t'((src_off - dst_off + LANES) % LANES);
        r_req_num_beats_i = beat_cnt_t'(src_beats);
        w_req_valid_i     = 1'b1;
        w_req_offset_i    = lane_idx_t'(dst_off);
        w_req_tailer_i    = lane_idx_t'(dst_tailer);
        w_req_shift_i     = lane_idx_t'((src_off - dst_off + LANES) % LANES);
        w_req_num_beats_i = beat_cnt_t'(dst_beats);

        while (r_rsp_seen == 0 || w_rsp_seen == 0) begin
            // Next source beat, possibly after a gap
            if (!in_valid_i && src_sent < src_beats && random_below(100) >= gap_pct) begin
                src_mask = lane_mask(src_sent, src_beats, src_off, src_tailer);
                for (int lane = 0; lane < LANES; lane++) begin
                    beat[lane*8 +: 8] = byte_t'(next_random());
                end
                in_data_i  = beat;
                in_valid_i = 1'b1;
            end
            out_ready_i   = (random_below(100) >= stall_pct);
            r_rsp_ready_i = (random_below(100) < rsp_pct);
            w_rsp_ready_i = (random_below(100) < rsp_pct);

            // A stalled beat must stay put
            if (stalled) begin
                check_value(32'(out_valid_o), 32'd1, "out_valid_o dropped while stalled");
                check_value(out_data_o, held_data, "out_data_o changed while stalled");
                check_value(32'(out_strb_o), 32'(held_strb), "out_strb_o changed while stalled");
                check_value(32'(out_last_o), 32'(held_last), "out_last_o changed while stalled");
            end

            r_req_fire = r_req_valid_i && r_req_ready_o;
            w_req_fire = w_req_valid_i && w_req_ready_o;
            in_fire    = in_valid_i && in_ready_o;
            if (in_fire) begin
                for (int lane = 0; lane < LANES; lane++) begin
                    if (src_mask[lane]) begin
                        model_q.push_back(in_data_i[lane*8 +: 8]);
                    end
                end
                src_sent++;
            end

            if (out_valid_o && out_ready_i) begin
                exp_strb = lane_mask(dst_recv, dst_beats, dst_off, dst_tailer);
                check_value(32'(out_strb_o), 32'(exp_strb), "out_strb_o");
                check_value(32'(out_last_o), 32'(dst_recv == dst_beats - 1), "out_last_o");
                for (int lane = 0; lane < LANES; lane++) begin
                    if (!exp_strb[lane]) begin
                        check_value(32'(out_data_o[lane*8 +: 8]), 32'd0, "unmasked lane");
                    end else if (model_q.size() == 0) begin
                        check_value(32'd0, 32'd1, "source byte left for strobed lane");
                    end else begin
                        check_value(32'(out_data_o[lane*8 +: 8]), 32'(model_q.pop_front()),
                                    "delivered byte");
                    end
                end
                dst_recv++;
            end
            stalled   = out_valid_o && !out_ready_i;
            held_data = out_data_o;
            held_strb = out_strb_o;
            held_last = out_last_o;

            if (r_rsp_valid_o && r_rsp_ready_i) begin
                r_rsp_seen++;
            end
            if (w_rsp_valid_o && w_rsp_ready_i) begin
                w_rsp_seen++;
            end

            @(negedge clk_i);
            if (r_req_fire) begin
                r_req_valid_i = 1'b0;
            end
            if (w_req_fire) begin
                w_req_valid_i = 1'b0;
            end
            if (in_fire) begin
                in_valid_i = 1'b0;
            end
        end

        out_ready_i   = 1'b0;
        r_rsp_ready_i = 1'b0;
        w_rsp_ready_i = 1'b0;
        check_value(32'(r_rsp_seen), 32'd1, "read responses per transfer");
        check_value(32'(w_rsp_seen), 32'd1, "write responses per transfer");
        check_value(32'(dst_recv), 32'(dst_beats), "output beats per transfer");
        check_value(32'(model_q.size()), 32'd0, "bytes left undelivered");
        // Both ports idle and the buffer drained
        repeat (2) begin
            check_value(32'(r_rsp_valid_o), 32'd0, "extra r_rsp_valid_o");
            check_value(32'(w_rsp_valid_o), 32'd0, "extra w_rsp_valid_o");
            check_value(32'(r_busy_o), 32'd0, "r_busy_o after response");
            check_value(32'(w_busy_o), 32'd0, "w_busy_o after response");
            check_value(32'(buffer_busy_o), 32'd0, "buffer_busy_o after response");
            @(negedge clk_i);
        end
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial begin : main
        int errors_before;
        int length;
        int src_off;
        int dst_off;
        rand_state        = 32'd14981;
        error_count       = 0;
        check_count       = 0;
        rst_n_i           = 1'b0;
        r_req_valid_i     = 1'b0;
        r_req_offset_i    = '0;
        r_req_tailer_i    = '0;
        r_req_shift_i     = '0;
        r_req_num_beats_i = '0;
        r_rsp_ready_i     = 1'b0;
        w_req_valid_i     = 1'b0;
        w_req_offset_i    = '0;
        w_req_tailer_i    = '0;
        w_req_shift_i     = '0;
        w_req_num_beats_i = '0;
        w_rsp_ready_i     = 1'b0;
        in_valid_i        = 1'b0;
        in_data_i         = '0;
        out_ready_i       = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);

        errors_before = error_count;
        check_value(32'(out_valid_o), 32'd0, "out_valid_o after reset");
        check_value(32'(in_ready_o), 32'd0, "in_ready_o after reset");
        check_value(32'(r_rsp_valid_o), 32'd0, "r_rsp_valid_o after reset");
        check_value(32'(w_rsp_valid_o), 32'd0, "w_rsp_valid_o after reset");
        check_value(32'(r_busy_o), 32'd0, "r_busy_o after reset");
        check_value(32'(w_busy_o), 32'd0, "w_busy_o after reset");
        check_value(32'(buffer_busy_o), 32'd0, "buffer_busy_o after reset");
        check_value(32'(r_req_ready_o), 32'd1, "r_req_ready_o after reset");
        check_value(32'(w_req_ready_o), 32'd1, "w_req_ready_o after reset");
        report_test(1, "reset values", errors_before);

        // Whole beats only, so every strobe is full
        errors_before = error_count;
        for (int t = 0; t < NUM_ALIGNED; t++) begin
            length = LANES * (1 + random_below(MAX_LENGTH / LANES));
            run_transfer(length, 0, 0, 0, 0, 100);
        end
        report_test(2, "aligned transfers", errors_before);

        errors_before = error_count;
        for (int t = 0; t < NUM_MISALIGNED; t++) begin
            length  = 1 + random_below(MAX_LENGTH);
            src_off = random_below(LANES);
            dst_off = random_below(LANES);
            run_transfer(length, src_off, dst_off, 0, 0, 100);
        end
        report_test(3, "misaligned transfers", errors_before);

        errors_before = error_count;
        for (int t = 0; t < NUM_STALLED; t++) begin
            length  = 1 + random_below(MAX_LENGTH);
            src_off = random_below(LANES);
            dst_off = random_below(LANES);
            run_transfer(length, src_off, dst_off, 30, 40, 100);
        end
        report_test(4, "input gaps and output stalls", errors_before);

        // Slow response acceptance
        errors_before = error_count;
        for (int t = 0; t < NUM_RESPONSE; t++) begin
            length  = 1 + random_below(MAX_LENGTH);
            src_off = random_below(LANES);
            dst_off = random_below(LANES);
            run_transfer(length, src_off, dst_off, 20, 20, 30);
        end
        report_test(5, "responses and busy outputs", errors_before);

        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (RESET_CYCLES + WATCHDOG_CYCLES) @(posedge clk_i);
        $display("Simulation timed out after %0d cycles, a transfer never completed",
                 RESET_CYCLES + WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: verilog/transport_layer.sv
`timescale 1ns/1ps
`include "tl_defines.svh"

module transport_layer
    import lane_pkg::*;
    import burst_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_n_i,

    // Read request and response
    input  logic      r_req_valid_i,
    output logic      r_req_ready_o,
    input  lane_idx_t r_req_offset_i,
    input  lane_idx_t r_req_tailer_i,
    input  lane_idx_t r_req_shift_i,
    input  beat_cnt_t r_req_num_beats_i,
    output logic      r_rsp_valid_o,
    input  logic      r_rsp_ready_i,

    // Write request and response
    input  logic      w_req_valid_i,
    output logic      w_req_ready_o,
    input  lane_idx_t w_req_offset_i,
    input  lane_idx_t w_req_tailer_i,
    input  lane_idx_t w_req_shift_i,
    input  beat_cnt_t w_req_num_beats_i,
    output logic      w_rsp_valid_o,
    input  logic      w_rsp_ready_i,

    // Source stream
    input  logic      in_valid_i,
    output logic      in_ready_o,
    input  data_t     in_data_i,

    // Destination stream
    output logic      out_valid_o,
    input  logic      out_ready_i,
    output data_t     out_data_o,
    output strb_t     out_strb_o,
    output logic      out_last_o,

    output logic      r_busy_o,
    output logic      w_busy_o,
    output logic      buffer_busy_o
);

    strb_t                      lane_push;
    strb_t                      lane_pop;
    strb_t                      lane_not_full;
    strb_t                      lane_not_empty;
    byte_t [`TL_STRB_WIDTH-1:0] lane_wdata;
    byte_t [`TL_STRB_WIDTH-1:0] lane_rdata;

    stream_read_port u_read_port (
        .clk_i             ( clk_i             ),
        .rst_n_i           ( rst_n_i           ),
        .r_req_valid_i     ( r_req_valid_i     ),
        .r_req_ready_o     ( r_req_ready_o     ),
        .r_req_offset_i    ( r_req_offset_i    ),
        .r_req_tailer_i    ( r_req_tailer_i    ),
        .r_req_shift_i     ( r_req_shift_i     ),
        .r_req_num_beats_i ( r_req_num_beats_i ),
        .in_valid_i        ( in_valid_i        ),
        .in_ready_o        ( in_ready_o        ),
        .in_data_i         ( in_data_i         ),
        .lane_push_o       ( lane_push         ),
        .lane_data_o       ( lane_wdata        ),
        .lane_not_full_i   ( lane_not_full     ),
        .r_rsp_valid_o     ( r_rsp_valid_o     ),
        .r_rsp_ready_i     ( r_rsp_ready_i     ),
        .r_busy_o          ( r_busy_o          )
    );

    // ----------------------------------------------------------------------
    // Reorder buffer, one FIFO per byte lane
    // ----------------------------------------------------------------------

    for (genvar i = 0; i < `TL_STRB_WIDTH; i++) begin : gen_lane
        byte_lane_fifo u_lane_fifo (
            .clk_i       ( clk_i             ),
            .rst_n_i     ( rst_n_i           ),
            .push_i      ( lane_push[i]      ),
            .data_i      ( lane_wdata[i]     ),
            .not_full_o  ( lane_not_full[i]  ),
            .pop_i       ( lane_pop[i]       ),
            .not_empty_o ( lane_not_empty[i] ),
            .data_o      ( lane_rdata[i]     )
        );
    end

    assign buffer_busy_o = |lane_not_empty;

    stream_write_port u_write_port (
        .clk_i             ( clk_i             ),
        .rst_n_i           ( rst_n_i           ),
        .w_req_valid_i     ( w_req_valid_i     ),
        .w_req_ready_o     ( w_req_ready_o     ),
        .w_req_offset_i    ( w_req_offset_i    ),
        .w_req_tailer_i    ( w_req_tailer_i    ),
        .w_req_shift_i     ( w_req_shift_i     ),
        .w_req_num_beats_i ( w_req_num_beats_i ),
        .lane_not_empty_i  ( lane_not_empty    ),
        .lane_data_i       ( lane_rdata        ),
        .lane_pop_o        ( lane_pop          ),
        .out_valid_o       ( out_valid_o       ),
        .out_ready_i       ( out_ready_i       ),
        .out_data_o        ( out_data_o        ),
        .out_strb_o        ( out_strb_o        ),
        .out_last_o        ( out_last_o        ),
        .w_rsp_valid_o     ( w_rsp_valid_o     ),
        .w_rsp_ready_i     ( w_rsp_ready_i     ),
        .w_busy_o          ( w_busy_o          )
    );

endmodule

// File: verilog/stream_write_port.sv
`timescale 1ns/1ps
`include "tl_defines.svh"

module stream_write_port
    import lane_pkg::*;
    import burst_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    input  logic                          w_req_valid_i,
    output logic                          w_req_ready_o,
    input  lane_idx_t                     w_req_offset_i,
    input  lane_idx_t                     w_req_tailer_i,
    input  lane_idx_t                     w_req_shift_i,
    input  beat_cnt_t                     w_req_num_beats_i,

    input  strb_t                         lane_not_empty_i,
    input  byte_t [`TL_STRB_WIDTH-1:0]    lane_data_i,
    output strb_t                         lane_pop_o,

    output logic                          out_valid_o,
    input  logic                          out_ready_i,
    output data_t                         out_data_o,
    output strb_t                         out_strb_o,
    output logic                          out_last_o,

    output logic                          w_rsp_valid_o,
    input  logic                          w_rsp_ready_i,
    output logic                          w_busy_o
);

    burst_state_e state_q;
    beat_cnt_t    beats_left_q;
    logic         first_q;
    lane_idx_t    offset_q;
    lane_idx_t    tailer_q;
    lane_idx_t    shift_q;

    logic         last_beat;
    logic         req_fire;
    logic         out_fire;
    logic         heads_ready;
    strb_t        beat_mask;
    strb_t        need_mask;

    assign req_fire  = w_req_valid_i && w_req_ready_o;
    assign last_beat = (beats_left_q <= beat_cnt_t'(1));
    assign beat_mask = beat_lane_mask(first_q, last_beat, offset_q, tailer_q);

    // ----------------------------------------------------------------------
    // Write rotation and invalid-lane masking
    // ----------------------------------------------------------------------

    always_comb begin : write_gather
        lane_idx_t src;
        src       = '0;
        need_mask = '0;
        for (int j = 0; j < `TL_STRB_WIDTH; j++) begin
            src              = lane_idx_t'(j - shift_q);
            need_mask[src]   = beat_mask[j];
            // Lanes outside the beat are driven as zero
            out_data_o[j*8 +: 8] = beat_mask[j] ? lane_data_i[src] : 8'h00;
        end
    end

    assign heads_ready = &(~need_mask | lane_not_empty_i);
    assign out_valid_o = (state_q == BURST_ACTIVE) && heads_ready;
    assign out_strb_o  = beat_mask;
    assign out_last_o  = (state_q == BURST_ACTIVE) && last_beat;
    assign out_fire    = out_valid_o && out_ready_i;

    // Pop only the buffer lanes that fed this beat
    assign lane_pop_o = out_fire ? need_mask : '0;

    assign w_req_ready_o = (state_q == BURST_IDLE);
    assign w_rsp_valid_o = (state_q == BURST_RESP);
    assign w_busy_o      = (state_q != BURST_IDLE);

    // ----------------------------------------------------------------------
    // Burst control
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin : burst_ctrl
        if (!rst_n_i) begin
            state_q      <= BURST_IDLE;
            beats_left_q <= '0;
            first_q      <= 1'b0;
        end else begin
            case (state_q)
                BURST_IDLE: begin
                    if (req_fire) begin
                        state_q      <= BURST_ACTIVE;
                        beats_left_q <= w_req_num_beats_i;
                        first_q      <= 1'b1;
                    end
                end
                BURST_ACTIVE: begin
                    if (out_fire) begin
                        first_q      <= 1'b0;
                        beats_left_q <= beats_left_q - beat_cnt_t'(1);
                        if (last_beat) begin
                            state_q <= BURST_RESP;
                        end
                    end
                end
                BURST_RESP: begin
                    if (w_rsp_ready_i) begin
                        state_q <= BURST_IDLE;
                    end
                end
                default: state_q <= BURST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin : req_latch
        if (req_fire) begin
            offset_q <= w_req_offset_i;
            tailer_q <= w_req_tailer_i;
            shift_q  <= w_req_shift_i;
        end
    end

endmodule

// File: verilog/stream_read_port.sv
`timescale 1ns/1ps
`include "tl_defines.svh"

module stream_read_port
    import lane_pkg::*;
    import burst_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rst_n_i,

    input  logic                          r_req_valid_i,
    output logic                          r_req_ready_o,
    input  lane_idx_t                     r_req_offset_i,
    input  lane_idx_t                     r_req_tailer_i,
    input  lane_idx_t                     r_req_shift_i,
    input  beat_cnt_t                     r_req_num_beats_i,

    input  logic                          in_valid_i,
    output logic                          in_ready_o,
    input  data_t                         in_data_i,

    output strb_t                         lane_push_o,
    output byte_t [`TL_STRB_WIDTH-1:0]    lane_data_o,
    input  strb_t                         lane_not_full_i,

    output logic                          r_rsp_valid_o,
    input  logic                          r_rsp_ready_i,
    output logic                          r_busy_o
);

    burst_state_e state_q;
    beat_cnt_t    beats_left_q;
    logic         first_q;
    lane_idx_t    offset_q;
    lane_idx_t    tailer_q;
    lane_idx_t    shift_q;

    logic         last_beat;
    logic         req_fire;
    logic         beat_fire;
    logic         room;
    strb_t        beat_mask;
    strb_t        push_mask;

    assign req_fire  = r_req_valid_i && r_req_ready_o;
    assign last_beat = (beats_left_q <= beat_cnt_t'(1));
    assign beat_mask = beat_lane_mask(first_q, last_beat, offset_q, tailer_q);

    // ----------------------------------------------------------------------
    // Read rotation
    // ----------------------------------------------------------------------

    // The write port rotates back by one shift on the way out, so the
    // buffer is filled with the beat rotated by two shifts
    always_comb begin : read_rotate
        lane_idx_t src;
        src = '0;
        for (int i = 0; i < `TL_STRB_WIDTH; i++) begin
            src            = lane_idx_t'(i + 2 * shift_q);
            lane_data_o[i] = in_data_i[src*8 +: 8];
            push_mask[i]   = beat_mask[src];
        end
    end

    // Every lane that takes a byte must have room
    assign room        = &(~push_mask | lane_not_full_i);
    assign in_ready_o  = (state_q == BURST_ACTIVE) && room;
    assign beat_fire   = in_valid_i && in_ready_o;
    assign lane_push_o = beat_fire ? push_mask : '0;

    assign r_req_ready_o = (state_q == BURST_IDLE);
    assign r_rsp_valid_o = (state_q == BURST_RESP);
    assign r_busy_o      = (state_q != BURST_IDLE);

    // ----------------------------------------------------------------------
    // Burst control
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin : burst_ctrl
        if (!rst_n_i) begin
            state_q      <= BURST_IDLE;
            beats_left_q <= '0;
            first_q      <= 1'b0;
        end else begin
            case (state_q)
                BURST_IDLE: begin
                    if (req_fire) begin
                        state_q      <= BURST_ACTIVE;
                        beats_left_q <= r_req_num_beats_i;
                        first_q      <= 1'b1;
                    end
                end
                BURST_ACTIVE: begin
                    if (beat_fire) begin
                        first_q      <= 1'b0;
                        beats_left_q <= beats_left_q - beat_cnt_t'(1);
                        if (last_beat) begin
                            state_q <= BURST_RESP;
                        end
                    end
                end
                BURST_RESP: begin
                    if (r_rsp_ready_i) begin
                        state_q <= BURST_IDLE;
                    end
                end
                default: state_q <= BURST_IDLE;
            endcase
        end
    end

    // Request fields, held for the whole burst
    always_ff @(posedge clk_i) begin : req_latch
        if (req_fire) begin
            offset_q <= r_req_offset_i;
            tailer_q <= r_req_tailer_i;
            shift_q  <= r_req_shift_i;
        end
    end

endmodule

// File: verilog/byte_lane_fifo.sv
`timescale 1ns/1ps
`include "tl_defines.svh"

module byte_lane_fifo
    import lane_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_n_i,
    input  logic  push_i,
    input  byte_t data_i,
    output logic  not_full_o,
    input  logic  pop_i,
    output logic  not_empty_o,
    output byte_t data_o
);

    localparam int unsigned DEPTH = `TL_BUFFER_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef logic [PTR_W-1:0]            ptr_t;
    typedef logic [$clog2(DEPTH+1)-1:0]  cnt_t;

    byte_t mem_q [DEPTH];
    ptr_t  wr_ptr_q;
    ptr_t  rd_ptr_q;
    cnt_t  count_q;
    logic  push_en;
    logic  pop_en;

    assign not_full_o  = (count_q != cnt_t'(DEPTH));
    assign not_empty_o = (count_q != '0);
    assign push_en     = push_i && not_full_o;
    assign pop_en      = pop_i && not_empty_o;

    // Head byte, only meaningful while not empty
    assign data_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin : ptr_ctrl
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_en) begin
                wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
            end
            if (pop_en) begin
                rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
            end
            // Push and pop together leave the occupancy unchanged
            if (push_en && !pop_en) begin
                count_q <= count_q + cnt_t'(1);
            end else if (pop_en && !push_en) begin
                count_q <= count_q - cnt_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin : mem_write
        if (push_en) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

// File: verilog/burst_pkg.sv
`include "tl_defines.svh"

package burst_pkg;
    import lane_pkg::*;

    typedef logic [`TL_BEAT_CNT_WIDTH-1:0] beat_cnt_t;

    typedef enum logic [1:0] {
        BURST_IDLE,
        BURST_ACTIVE,
        BURST_RESP
    } burst_state_e;

    // Lanes covered by one beat: first beat from offset up, last beat below tailer
    function automatic strb_t beat_lane_mask(input logic first, input logic last,
                                             input lane_idx_t offset,
                                             input lane_idx_t tailer);
        strb_t mask;
        mask = '1;
        if (first) begin
            mask = mask & (strb_t'('1) << offset);
        end
        // A tailer of zero means the last beat is full
        if (last && (tailer != '0)) begin
            mask = mask & ~(strb_t'('1) << tailer);
        end
        return mask;
    endfunction

endpackage

// File: verilog/lane_pkg.sv
`include "tl_defines.svh"

package lane_pkg;

    // One data byte
    typedef logic [7:0] byte_t;

    // One bit per byte lane
    typedef logic [`TL_STRB_WIDTH-1:0] strb_t;

    // Lane number, used for offset, tailer and shift
    typedef logic [$clog2(`TL_STRB_WIDTH)-1:0] lane_idx_t;

    // One full stream beat
    typedef logic [`TL_STRB_WIDTH*8-1:0] data_t;

endpackage

// File: include/tl_defines.svh
`ifndef TL_DEFINES_SVH
`define TL_DEFINES_SVH

// Byte lanes per stream beat
`define TL_STRB_WIDTH 4

// Entries in each byte-lane FIFO of the reorder buffer
`define TL_BUFFER_DEPTH 3

// Width of a burst's beat count
`define TL_BEAT_CNT_WIDTH 8

`endif
